// File: project.f
verilog/rx_pkg.sv
verilog/cq_framer.sv
verilog/cq_req_decoder.sv
verilog/cq_write_packer.sv
verilog/rx_throughput_meter.sv
verilog/rx_sequence_checker.sv
verilog/rx_engine_top.sv
sim/rx_engine_tb_assert.sv
sim/rx_engine_tb.sv

// File: sim/rx_engine_tb.sv
////////////////////////////////////////////////////////////
// testbench for the cq receive engine
// packet table, fifo word model, read handshake, statistics
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_engine_tb;

   localparam int unsigned WINDOW_CYCLES = 64;   // short window for simulation
   localparam int unsigned SEQ_W         = 10;
   localparam int          NUM_PKTS      = 14;

   typedef struct packed {
      logic [3:0]  op;
      logic [10:0] len;    // dw count
      logic [7:0]  tag;
      logic [10:0] addr;
      logic [31:0] seq;    // first payload dw
   } pkt_t;

   logic                      clk = 1'b0;
   logic                      rst_n;
   logic [rx_pkg::DATA_W-1:0] cq_tdata;
   logic                      cq_tlast;
   logic                      cq_tvalid;
   logic [7:0]                cq_tuser_be;
   logic                      cq_tready;
   logic                      req_compl;
   rx_pkg::mem_rd_req_t       rd_req;
   logic                      compl_done;
   logic                      fifo_wr;
   rx_pkg::fifo_word_t        fifo_data;
   logic                      stats_clear;
   logic                      tput_valid;
   logic [31:0]               tput_count;
   logic                      seq_error;

   pkt_t                pkt_table [NUM_PKTS];
   logic [31:0]         payload [32];
   rx_pkg::fifo_word_t  exp_words [$];           // words still owed by the DUT
   logic [31:0]         exp_total   = '0;
   logic [31:0]         tput_sum    = '0;
   logic [SEQ_W-1:0]    exp_seq     = '0;
   logic                seq_err_model = 1'b0;
   logic                rd_expected = 1'b0;      // a one-dw read is in flight
   integer              seed        = 41;
   int                  cycle_cnt   = 0;
   int                  cycle_limit = 1000000;   // replaced before the first edge

   always #10 clk = ~clk;   // 20 ns

   rx_engine_top #(
      .WINDOW_CYCLES (WINDOW_CYCLES),
      .SEQ_W         (SEQ_W)
   ) dut_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .cq_tdata_i    (cq_tdata),
      .cq_tlast_i    (cq_tlast),
      .cq_tvalid_i   (cq_tvalid),
      .cq_tuser_be_i (cq_tuser_be),
      .cq_tready_o   (cq_tready),
      .req_compl_o   (req_compl),
      .rd_req_o      (rd_req),
      .compl_done_i  (compl_done),
      .fifo_wr_o     (fifo_wr),
      .fifo_data_o   (fifo_data),
      .stats_clear_i (stats_clear),
      .tput_valid_o  (tput_valid),
      .tput_count_o  (tput_count),
      .seq_error_o   (seq_error)
   );

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////
   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_word(input string name, input rx_pkg::fifo_word_t got,
                               input rx_pkg::fifo_word_t exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_rd_req(input string name, input rx_pkg::mem_rd_req_t got,
                                 input rx_pkg::mem_rd_req_t exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_count(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s got %0d expected %0d", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s got %b expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   // values read at an edge are the ones from before that edge
   always @(posedge clk) begin
      if (rst_n) begin
         if (req_compl && cq_tready) begin
            $display("cq_tready_o was high during the completion wait");
            abort_run();
         end
         if (req_compl && !rd_expected) begin
            $display("req_compl_o was raised for a request that must be ignored");
            abort_run();
         end
         if (fifo_wr && req_compl) begin
            $display("fifo_wr_o pulsed while a read was waiting");
            abort_run();
         end
         if (fifo_wr) begin
            if (exp_words.size() == 0) begin
               $display("fifo_wr_o pulsed when no fifo word was expected");
               abort_run();
            end
            compare_word("fifo_data_o", fifo_data, exp_words.pop_front());
         end
         if (tput_valid) begin
            tput_sum = tput_sum + tput_count;   // one result per window
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
         abort_run();
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////
   function automatic logic [rx_pkg::DATA_W-1:0] make_header(input pkt_t p);
      logic [rx_pkg::DATA_W-1:0] h;
      h = '0;
      h[rx_pkg::ADDR_MSB:rx_pkg::ADDR_LSB] = p.addr;
      h[rx_pkg::LEN_MSB:rx_pkg::LEN_LSB]   = p.len;
      h[rx_pkg::OP_MSB:rx_pkg::OP_LSB]     = p.op;
      h[rx_pkg::RID_MSB:rx_pkg::RID_LSB]   = 16'h0a01;   // fixed requester
      h[rx_pkg::TAG_MSB:rx_pkg::TAG_LSB]   = p.tag;
      h[rx_pkg::TC_MSB:rx_pkg::TC_LSB]     = 3'd5;
      h[rx_pkg::ATTR_MSB:rx_pkg::ATTR_LSB] = 2'd2;
      return h;
   endfunction

   // beats, drain and read wait per entry, plus reset and two windows
   function automatic int cycle_budget();
      int total;
      int i;
      total = 16 + 2 * WINDOW_CYCLES + 200;
      for (i = 0; i < NUM_PKTS; i++) begin
         total = total + 10 + (int'(pkt_table[i].len) + 7) / 8;
         if (pkt_table[i].op == rx_pkg::OP_MEM_RD) begin
            total = total + 12;   // random delay is at most 4
         end
      end
      return total;
   endfunction

   task automatic send_beat(input logic [rx_pkg::DATA_W-1:0] data, input logic last,
                            input logic [7:0] be);
      cq_tdata    <= data;
      cq_tlast    <= last;
      cq_tuser_be <= be;
      cq_tvalid   <= 1'b1;
      @(posedge clk);
      while (!cq_tready) begin
         @(posedge clk);   // held by a read wait
      end
   endtask

   task automatic serve_read(input rx_pkg::mem_rd_req_t exp);
      int delay;
      do @(posedge clk); while (!req_compl);
      compare_rd_req("rd_req_o", rd_req, exp);
      compare_bit("cq_tready_o", cq_tready, 1'b0);
      delay = 1 + ($unsigned($random(seed)) % 4);
      repeat (delay) begin
         @(posedge clk);
         compare_bit("cq_tready_o", cq_tready, 1'b0);
      end
      compl_done <= 1'b1;
      @(posedge clk);   // done sampled here
      compl_done <= 1'b0;
      compare_bit("cq_tready_o", cq_tready, 1'b0);
      @(posedge clk);
      compare_bit("cq_tready_o", cq_tready, 1'b1);
      compare_bit("req_compl_o", req_compl, 1'b0);
      rd_expected = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_words.size() != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
   endtask

   task automatic play_packet(input pkt_t p);
      int                        n_data;
      int                        remain;
      int                        k;
      int                        j;
      int                        idx;
      logic                      is_wr;
      logic                      is_rd;
      logic [rx_pkg::DATA_W-1:0] beat;
      rx_pkg::fifo_word_t        word;
      rx_pkg::mem_rd_req_t       exp_rd;
      is_wr  = (p.op == rx_pkg::OP_MEM_WR);
      is_rd  = (p.op == rx_pkg::OP_MEM_RD) && (p.len == 11'd1);
      n_data = (is_wr && p.len > 4) ? (int'(p.len) + 3) / 8 : 0;
      for (idx = 0; idx < 32; idx++) begin
         if (idx >= p.len) payload[idx] = '0;   // past the packet end
         else if (idx == 0) payload[idx] = p.seq;
         else payload[idx] = $random(seed);
      end
      // word k holds payload dw 8k-8 up
      if (is_wr) begin
         if (p.seq[SEQ_W-1:0] != exp_seq) seq_err_model = 1'b1;
         exp_seq = exp_seq + 1'b1;
         remain  = p.len;
         for (k = 1; k <= ((p.len <= 4) ? 1 : n_data); k++) begin
            word.data = '0;
            for (j = 0; j < 8; j++) begin
               word.data[32*j +: 32] = payload[8*(k-1) + j];
            end
            word.first = (k == 1);
            word.last  = (remain <= 8);   // tlast can end a packet before this
            exp_words.push_back(word);
            exp_total = exp_total + 1;
            remain    = remain - 8;
         end
      end
      exp_rd = '{tc: 3'd5, attr: 2'd2, len: p.len[9:0], rid: 16'h0a01, tag: p.tag,
                 be: 8'h0f, td: 1'b0, ep: 1'b0, addr: p.addr, spare: 1'b0};
      beat = make_header(p);
      for (j = 0; j < 4; j++) begin
         beat[rx_pkg::PAYLOAD_LSB + 32*j +: 32] = payload[j];
      end
      if (is_rd) rd_expected = 1'b1;
      send_beat(beat, n_data == 0, 8'h0f);
      for (k = 1; k <= n_data; k++) begin
         for (j = 0; j < 8; j++) begin
            idx = 4 + 8*(k-1) + j;
            beat[32*j +: 32] = payload[idx];
         end
         send_beat(beat, k == n_data, 8'h00);
      end
      cq_tvalid <= 1'b0;
      cq_tlast  <= 1'b0;
      cq_tdata  <= '0;
      if (is_rd) serve_read(exp_rd);
      wait_drain();
      compare_bit("seq_error_o", seq_error, seq_err_model);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      int i;
      rst_n       = 1'b0;
      cq_tdata    = '0;
      cq_tlast    = 1'b0;
      cq_tvalid   = 1'b0;
      cq_tuser_be = '0;
      compl_done  = 1'b0;
      stats_clear = 1'b0;
      //               op                  len     tag    addr     seq
      pkt_table[0]  = '{rx_pkg::OP_MEM_WR, 11'd1,  8'h00, 11'h000, 32'd0};
      pkt_table[1]  = '{rx_pkg::OP_MEM_WR, 11'd2,  8'h00, 11'h000, 32'd1};
      pkt_table[2]  = '{rx_pkg::OP_MEM_RD, 11'd1,  8'h5a, 11'h2c4, 32'd0};
      pkt_table[3]  = '{rx_pkg::OP_MEM_WR, 11'd3,  8'h00, 11'h000, 32'd2};
      pkt_table[4]  = '{rx_pkg::OP_MEM_WR, 11'd4,  8'h00, 11'h000, 32'd3};
      pkt_table[5]  = '{rx_pkg::OP_MEM_RD, 11'd2,  8'h11, 11'h010, 32'd0};   // dropped
      pkt_table[6]  = '{4'h5,              11'd4,  8'h22, 11'h020, 32'd0};   // dropped
      pkt_table[7]  = '{rx_pkg::OP_MEM_WR, 11'd5,  8'h00, 11'h000, 32'd4};
      pkt_table[8]  = '{rx_pkg::OP_MEM_WR, 11'd8,  8'h00, 11'h000, 32'd5};
      pkt_table[9]  = '{rx_pkg::OP_MEM_RD, 11'd1,  8'ha3, 11'h7ff, 32'd0};
      pkt_table[10] = '{rx_pkg::OP_MEM_WR, 11'd12, 8'h00, 11'h000, 32'd6};
      pkt_table[11] = '{rx_pkg::OP_MEM_WR, 11'd20, 8'h00, 11'h000, 32'd7};
      pkt_table[12] = '{rx_pkg::OP_MEM_WR, 11'd2,  8'h00, 11'h000, 32'd9};   // skips 8
      pkt_table[13] = '{rx_pkg::OP_MEM_WR, 11'd1,  8'h00, 11'h000, 32'd9};
      cycle_limit = cycle_budget();
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      compare_bit("cq_tready_o", cq_tready, 1'b1);
      compare_bit("req_compl_o", req_compl, 1'b0);
      compare_bit("fifo_wr_o", fifo_wr, 1'b0);
      compare_bit("tput_valid_o", tput_valid, 1'b0);
      compare_bit("seq_error_o", seq_error, 1'b0);
      for (i = 0; i < NUM_PKTS; i++) begin
         play_packet(pkt_table[i]);
      end
      repeat (2 * WINDOW_CYCLES + 4) @(posedge clk);   // close every open window
      compare_count("tput_count_o sum", tput_sum, exp_total);
      compare_bit("seq_error_o", seq_error, 1'b1);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/rx_engine_tb_assert.sv
////////////////////////////////////////////////////////////
// port level assertions for the cq receive engine
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_engine_tb_assert (
   input wire clk,
   input wire rst_n,
   input wire cq_tready_i,
   input wire req_compl_i,
   input wire fifo_wr_i
);

   // stream is held for the whole completion wait
   assert property (@(posedge clk) disable iff (!rst_n) req_compl_i |-> !cq_tready_i)
      else $error("cq_tready_o high while req_compl_o is pending");

   // no fifo traffic while a read is open
   assert property (@(posedge clk) disable iff (!rst_n) req_compl_i |-> !fifo_wr_i)
      else $error("fifo_wr_o pulsed during the completion wait");

   // a read only starts from an open stream
   assert property (@(posedge clk) disable iff (!rst_n) $rose(req_compl_i) |-> $past(cq_tready_i))
      else $error("req_compl_o rose while the stream was already held");

endmodule

bind rx_engine_top rx_engine_tb_assert assert_i (
   .clk          (clk),
   .rst_n        (rst_n),
   .cq_tready_i  (cq_tready_o),
   .req_compl_i  (req_compl_o),
   .fifo_wr_i    (fifo_wr_o)
);

`default_nettype wire

// File: verilog/rx_engine_top.sv
////////////////////////////////////////////////////////////
// cq receive engine, framer, decoder, packer and statistics
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_engine_top #(
   parameter int unsigned WINDOW_CYCLES = 25000000,   // throughput window in cycles
   parameter int unsigned SEQ_W         = 10
) (
   input  wire                        clk,
   input  wire                        rst_n,
   // completer request stream
   input  wire [rx_pkg::DATA_W-1:0]   cq_tdata_i,
   input  wire                        cq_tlast_i,
   input  wire                        cq_tvalid_i,
   input  wire [7:0]                  cq_tuser_be_i,
   output logic                       cq_tready_o,
   // completion transmitter handshake
   output logic                       req_compl_o,
   output rx_pkg::mem_rd_req_t        rd_req_o,
   input  wire                        compl_done_i,
   // receive fifo
   output logic                       fifo_wr_o,
   output rx_pkg::fifo_word_t         fifo_data_o,
   // statistics
   input  wire                        stats_clear_i,
   output logic                       tput_valid_o,
   output logic [31:0]                tput_count_o,
   output logic                       seq_error_o
);

   rx_pkg::cq_beat_t             beat;
   logic                         wr_start;
   logic [rx_pkg::DW_LEN_W-1:0]  wr_len;

   cq_framer framer_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .tdata_i    (cq_tdata_i),
      .tlast_i    (cq_tlast_i),
      .tvalid_i   (cq_tvalid_i),
      .tuser_be_i (cq_tuser_be_i),
      .tready_i   (cq_tready_o),
      .beat_o     (beat)
   );

   cq_req_decoder decoder_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat_i       (beat),
      .compl_done_i (compl_done_i),
      .tready_o     (cq_tready_o),
      .req_compl_o  (req_compl_o),
      .rd_req_o     (rd_req_o),
      .wr_start_o   (wr_start),
      .wr_len_o     (wr_len)
   );

   cq_write_packer packer_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat_i     (beat),
      .wr_start_i (wr_start),
      .wr_len_i   (wr_len),
      .fifo_wr_o  (fifo_wr_o),
      .fifo_o     (fifo_data_o)
   );

   ////////////////////////////////////////////////////////////
   // statistics on the fifo side
   ////////////////////////////////////////////////////////////
   rx_throughput_meter #(
      .WINDOW_CYCLES (WINDOW_CYCLES)
   ) meter_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .stats_clear_i (stats_clear_i),
      .fifo_wr_i     (fifo_wr_o),
      .tput_valid_o  (tput_valid_o),
      .tput_count_o  (tput_count_o)
   );

   rx_sequence_checker #(
      .SEQ_W (SEQ_W)
   ) seq_chk_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .stats_clear_i (stats_clear_i),
      .fifo_wr_i     (fifo_wr_o),
      .fifo_i        (fifo_data_o),
      .seq_error_o   (seq_error_o)
   );

endmodule

`default_nettype wire

// File: verilog/rx_sequence_checker.sv
////////////////////////////////////////////////////////////
// packet sequence check on the first fifo word
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_sequence_checker #(
   parameter int unsigned SEQ_W = 10
) (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire                       stats_clear_i,
   input  wire                       fifo_wr_i,
   input  wire rx_pkg::fifo_word_t   fifo_i,
   output logic                      seq_error_o
);

   logic [SEQ_W-1:0] exp_seq_q;   // number the next packet should carry
   logic             first_wr;

   assign first_wr = fifo_wr_i && fifo_i.first;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         exp_seq_q   <= '0;
         seq_error_o <= 1'b0;
      end else if (stats_clear_i) begin
         exp_seq_q   <= '0;
         seq_error_o <= 1'b0;
      end else if (first_wr) begin
         // dw0 low bits hold the sender's count
         if (fifo_i.data[SEQ_W-1:0] != exp_seq_q) begin
            seq_error_o <= 1'b1;   // sticky until clear
         end
         exp_seq_q <= exp_seq_q + 1'b1;   // wraps at width
      end
   end

endmodule

`default_nettype wire

// File: verilog/rx_throughput_meter.sv
////////////////////////////////////////////////////////////
// fifo words per fixed window of cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_throughput_meter #(
   parameter int unsigned WINDOW_CYCLES = 25000000
) (
   input  wire          clk,
   input  wire          rst_n,
   input  wire          stats_clear_i,
   input  wire          fifo_wr_i,
   output logic         tput_valid_o,
   output logic [31:0]  tput_count_o
);

   localparam int unsigned CNT_W = (WINDOW_CYCLES > 1) ? $clog2(WINDOW_CYCLES) : 1;

   logic [CNT_W-1:0] win_cnt_q;    // cycle position in the window
   logic [31:0]      word_cnt_q;   // words seen so far this window
   logic             win_end;

   assign win_end = (win_cnt_q == CNT_W'(WINDOW_CYCLES - 1));

   ////////////////////////////////////////////////////////////
   // window and word counters
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_cnt_q    <= '0;
         word_cnt_q   <= '0;
         tput_valid_o <= 1'b0;
      end else if (stats_clear_i) begin
         win_cnt_q    <= '0;   // restart the window too
         word_cnt_q   <= '0;
         tput_valid_o <= 1'b0;
      end else begin
         tput_valid_o <= win_end;
         if (win_end) begin
            win_cnt_q  <= '0;
            word_cnt_q <= {31'd0, fifo_wr_i};   // closing cycle word goes to the new window
         end else begin
            win_cnt_q <= win_cnt_q + 1'b1;
            if (fifo_wr_i) begin
               word_cnt_q <= word_cnt_q + 1'b1;
            end
         end
      end
   end

   // result, qualified by tput_valid_o
   always_ff @(posedge clk) begin
      if (win_end && !stats_clear_i) begin
         tput_count_o <= word_cnt_q;
      end
   end

endmodule

`default_nettype wire

// File: verilog/cq_write_packer.sv
////////////////////////////////////////////////////////////
// write payload repacking into 256-bit fifo words
// carries the upper half of each beat into the next word
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cq_write_packer (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire rx_pkg::cq_beat_t         beat_i,
   input  wire                           wr_start_i,
   input  wire [rx_pkg::DW_LEN_W-1:0]    wr_len_i,
   output logic                          fifo_wr_o,
   output rx_pkg::fifo_word_t            fifo_o
);

   localparam int unsigned HALF_W = rx_pkg::DATA_W / 2;

   logic                         receiving_q;   // long write in progress
   logic                         first_q;       // next word opens the packet
   logic [rx_pkg::DW_LEN_W-1:0]  remain_q;      // dw still owed, incl. carried half
   logic [HALF_W-1:0]            carry_q;       // upper half of the previous beat
   logic                         short_wr;
   logic                         data_beat;
   logic                         final_word;
   logic [rx_pkg::DATA_W-1:0]    short_data;

   assign short_wr   = wr_start_i && (wr_len_i <= rx_pkg::DW_LEN_W'(rx_pkg::FIRST_BEAT_DW));
   assign data_beat  = receiving_q && beat_i.accepted;
   assign final_word = (remain_q <= rx_pkg::DW_LEN_W'(rx_pkg::BEAT_DW));

   // header payload zero padded past the packet length
   always_comb begin
      short_data = '0;
      for (int i = 0; i < rx_pkg::FIRST_BEAT_DW; i++) begin
         if (wr_len_i > rx_pkg::DW_LEN_W'(i)) begin
            short_data[i*32 +: 32] = beat_i.data[rx_pkg::PAYLOAD_LSB + i*32 +: 32];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fifo_wr_o   <= 1'b0;
         receiving_q <= 1'b0;
         first_q     <= 1'b0;
         remain_q    <= '0;
      end else begin
         fifo_wr_o <= 1'b0;   // single cycle strobe
         if (short_wr) begin
            fifo_wr_o   <= 1'b1;
            receiving_q <= 1'b0;
         end else if (wr_start_i) begin
            receiving_q <= 1'b1;   // header beat only loads the carry
            first_q     <= 1'b1;
            remain_q    <= wr_len_i;
         end else if (data_beat) begin
            fifo_wr_o <= 1'b1;
            first_q   <= 1'b0;
            remain_q  <= remain_q - rx_pkg::DW_LEN_W'(rx_pkg::BEAT_DW);
            if (final_word || beat_i.last) begin
               receiving_q <= 1'b0;   // tlast also ends a cut short packet
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // data path
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (short_wr) begin
         fifo_o.data  <= short_data;
         fifo_o.first <= 1'b1;
         fifo_o.last  <= 1'b1;
      end else if (data_beat) begin
         fifo_o.data  <= {beat_i.data[HALF_W-1:0], carry_q};   // older dw in the low half
         fifo_o.first <= first_q;
         fifo_o.last  <= final_word;
      end
      if (wr_start_i || data_beat) begin
         carry_q <= beat_i.data[rx_pkg::DATA_W-1:HALF_W];
      end
   end

endmodule

`default_nettype wire

// File: verilog/cq_req_decoder.sv
////////////////////////////////////////////////////////////
// header decode, one-dw read capture and completion wait
// write start strobe and tready control
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cq_req_decoder (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire rx_pkg::cq_beat_t         beat_i,
   input  wire                           compl_done_i,
   output logic                          tready_o,
   output logic                          req_compl_o,
   output rx_pkg::mem_rd_req_t           rd_req_o,
   output logic                          wr_start_o,
   output logic [rx_pkg::DW_LEN_W-1:0]   wr_len_o
);

   typedef enum logic {
      ST_IDLE,
      ST_RD_WAIT   // read handed off, waiting on the completer
   } state_t;

   state_t                       state_q;
   rx_pkg::opcode_t              opcode;
   logic [rx_pkg::DW_LEN_W-1:0]  len;
   logic                         hdr_valid;
   logic                         rd_hit;

   assign opcode    = rx_pkg::opcode_t'(beat_i.data[rx_pkg::OP_MSB:rx_pkg::OP_LSB]);
   assign len       = beat_i.data[rx_pkg::LEN_MSB:rx_pkg::LEN_LSB];
   assign hdr_valid = beat_i.accepted && beat_i.sop && (state_q == ST_IDLE);

   // only single dw reads get a completion, longer ones are dropped
   assign rd_hit = hdr_valid && (opcode == rx_pkg::OP_MEM_RD) &&
                   (len == rx_pkg::DW_LEN_W'(1));

   // writes of any length go straight to the packer, same cycle
   assign wr_start_o = hdr_valid && (opcode == rx_pkg::OP_MEM_WR);
   assign wr_len_o   = len;

   ////////////////////////////////////////////////////////////
   // read handshake fsm
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q     <= ST_IDLE;
         tready_o    <= 1'b1;
         req_compl_o <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (rd_hit) begin
                  state_q     <= ST_RD_WAIT;
                  tready_o    <= 1'b0;   // hold the stream until completion
                  req_compl_o <= 1'b1;
               end
            end
            ST_RD_WAIT: begin
               if (compl_done_i) begin
                  state_q     <= ST_IDLE;
                  tready_o    <= 1'b1;
                  req_compl_o <= 1'b0;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // request fields, loaded with req_compl_o
   always_ff @(posedge clk) begin
      if (rd_hit) begin
         rd_req_o.tc    <= beat_i.data[rx_pkg::TC_MSB:rx_pkg::TC_LSB];
         rd_req_o.attr  <= beat_i.data[rx_pkg::ATTR_MSB:rx_pkg::ATTR_LSB];
         rd_req_o.len   <= len[9:0];
         rd_req_o.rid   <= beat_i.data[rx_pkg::RID_MSB:rx_pkg::RID_LSB];
         rd_req_o.tag   <= beat_i.data[rx_pkg::TAG_MSB:rx_pkg::TAG_LSB];
         rd_req_o.be    <= beat_i.first_be;
         rd_req_o.td    <= 1'b0;   // no digest
         rd_req_o.ep    <= 1'b0;   // never poisoned
         rd_req_o.addr  <= beat_i.data[rx_pkg::ADDR_MSB:rx_pkg::ADDR_LSB];   // dw address
         rd_req_o.spare <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/cq_framer.sv
////////////////////////////////////////////////////////////
// cq stream framing, start of packet and beat acceptance
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cq_framer (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire [rx_pkg::DATA_W-1:0]   tdata_i,
   input  wire                        tlast_i,
   input  wire                        tvalid_i,
   input  wire [7:0]                  tuser_be_i,
   input  wire                        tready_i,
   output rx_pkg::cq_beat_t           beat_o
);

   logic in_pkt_q;   // a packet is open, one cycle behind the bus
   logic sop;
   logic accepted;

   assign sop      = tvalid_i && !in_pkt_q;
   assign accepted = tvalid_i && tready_i;

   ////////////////////////////////////////////////////////////
   // packet tracking
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q <= 1'b0;
      end else if (accepted && tlast_i) begin
         in_pkt_q <= 1'b0;   // closes even on a one-beat packet
      end else if (accepted && sop) begin
         in_pkt_q <= 1'b1;
      end
   end

   // bundle the beat so later stages skip the framing tests
   always_comb begin
      beat_o.data     = tdata_i;
      beat_o.last     = tlast_i;
      beat_o.first_be = tuser_be_i;   // first/last dw byte enables
      beat_o.sop      = sop;
      beat_o.accepted = accepted;
   end

endmodule

`default_nettype wire

// File: verilog/rx_pkg.sv
////////////////////////////////////////////////////////////
// shared widths, opcodes and header field positions
// beat, read request and fifo word structs
////////////////////////////////////////////////////////////
`default_nettype none

package rx_pkg;

   localparam int unsigned DATA_W   = 256;   // cq beat width
   localparam int unsigned DW_LEN_W = 11;    // dw count field
   localparam int unsigned ADDR_W   = 11;    // captured read address

   // request type, 4 bits of the descriptor
   typedef enum logic [3:0] {
      OP_MEM_RD = 4'b0000,
      OP_MEM_WR = 4'b0001
   } opcode_t;

   ////////////////////////////////////////////////////////////
   // descriptor field positions in the header beat
   ////////////////////////////////////////////////////////////
   localparam int unsigned ADDR_LSB    = 2;
   localparam int unsigned ADDR_MSB    = 12;
   localparam int unsigned LEN_LSB     = 64;
   localparam int unsigned LEN_MSB     = 74;
   localparam int unsigned OP_LSB      = 75;
   localparam int unsigned OP_MSB      = 78;
   localparam int unsigned RID_LSB     = 80;
   localparam int unsigned RID_MSB     = 95;
   localparam int unsigned TAG_LSB     = 96;
   localparam int unsigned TAG_MSB     = 103;
   localparam int unsigned TC_LSB      = 121;
   localparam int unsigned TC_MSB      = 123;
   localparam int unsigned ATTR_LSB    = 124;
   localparam int unsigned ATTR_MSB    = 125;
   localparam int unsigned PAYLOAD_LSB = 128;   // dw0 of the header beat

   localparam int unsigned FIRST_BEAT_DW = 4;   // payload dw riding with the header
   localparam int unsigned BEAT_DW       = 8;   // dw per later beat

   // one cq beat plus framing flags from the framer
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
      logic [7:0]        first_be;
      logic              sop;        // first beat of a packet
      logic              accepted;   // valid and ready this cycle
   } cq_beat_t;

   // captured one-dw read, handed to the completer
   typedef struct packed {
      logic [2:0]        tc;
      logic [1:0]        attr;
      logic [9:0]        len;
      logic [15:0]       rid;
      logic [7:0]        tag;
      logic [7:0]        be;
      logic              td;
      logic              ep;
      logic [ADDR_W-1:0] addr;
      logic              spare;
   } mem_rd_req_t;

   // one receive fifo write
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              first;   // first word of a packet
      logic              last;    // final word of a packet
   } fifo_word_t;

endpackage

`default_nettype wire
